// ==== all.f ====
prefetch_pkg.sv
fetch_addr_gen.sv
fetch_fifo.sv
fetch_fsm.sv
prefetch_buffer.sv
tb_imem_model.sv
tb_prefetch_buffer.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the prefetch buffer testbench with Verilator
# pass or fail is taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
  --top-module tb_prefetch_buffer -Mdir obj_dir -o sim_prefetch \
  -f all.f || { echo "build failed"; exit 1; }
./obj_dir/sim_prefetch > sim.log 2>&1 ; cat sim.log
grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

// ==== tb_prefetch_buffer.sv ====
// testbench for the instruction prefetch buffer
// random back-pressure and branches against a random-latency memory
// with every accepted entry checked against the expected address stream
module tb_prefetch_buffer;
  import prefetch_pkg::*;

  localparam int          NUM_TXN    = 300;
  localparam int unsigned FIFO_DEPTH = 3;
  localparam logic [31:0] SEED       = 32'hcb236af2;

  logic         clk_i;
  logic         rst_ni;
  logic         req_i;
  logic         branch_i;
  logic         ready_i;
  logic         valid_o;
  logic         busy_o;
  logic         instr_req_o;
  logic         instr_gnt_i;
  logic         instr_rvalid_i;
  addr_t        addr_i;
  addr_t        rdata_o;
  addr_t        addr_o;
  addr_t        instr_addr_o;
  addr_t        instr_rdata_i;
  logic [31:0]  rng_q;
  int           accepted;
  int           mismatch_cnt;
  int           other_cnt;
  int           mem_err_cnt;
  addr_t        exp_addr;
  logic         hold_q;
  logic         branch_q;
  fetch_entry_t hold_entry;

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  prefetch_buffer #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_dut (.*);

  tb_imem_model #(
    .SEED(SEED)
  ) u_imem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .branch_i      (branch_i),
    .instr_req_i   (instr_req_o),
    .instr_addr_i  (instr_addr_o),
    .instr_gnt_o   (instr_gnt_i),
    .instr_rvalid_o(instr_rvalid_i),
    .instr_rdata_o (instr_rdata_i),
    .err_cnt_o     (mem_err_cnt)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] draw();
    rng_q = lcg_next(rng_q);
    return rng_q;
  endfunction

  // expected instruction word for a fetched byte address
  function automatic addr_t ref_word(input addr_t a);
    return ((a >> 2) * 32'h9e3779b1) ^ 32'h5a5a5a5a;
  endfunction

  task automatic report_mismatch(input string name, input addr_t got, input addr_t exp);
    $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    mismatch_cnt++;
  endtask

  task automatic report_error(input string what);
    $display("error at %0t: %s", $time, what);
    other_cnt++;
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors: %0d mismatch, %0d other, %0d memory protocol, %0d entries checked",
             mismatch_cnt, other_cnt, mem_err_cnt, accepted);
    if (!timed_out && mismatch_cnt + other_cnt + mem_err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // checker sampled on the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // a request on the bus is fetch activity
      assert (busy_o || !instr_req_o)
        else report_error("busy_o low while a request is on the bus");
      // flush leaves nothing to present in the cycle after a branch
      if (branch_q) begin
        assert (!valid_o) else report_error("valid_o high the cycle after a branch");
      end
      if (branch_i) begin
        exp_addr = {addr_i[31:2], 2'b00};
        hold_q   = 1'b0;
      end else begin
        // a stalled entry stays put
        if (hold_q) begin
          assert (valid_o) else report_error("valid_o dropped while ready_i was low");
          assert (addr_o == hold_entry.addr)
            else report_mismatch("addr_o", addr_o, hold_entry.addr);
          assert (rdata_o == hold_entry.data)
            else report_mismatch("rdata_o", rdata_o, hold_entry.data);
        end
        if (valid_o && ready_i) begin
          assert (addr_o == exp_addr) else report_mismatch("addr_o", addr_o, exp_addr);
          assert (rdata_o == ref_word(addr_o))
            else report_mismatch("rdata_o", rdata_o, ref_word(addr_o));
          // next word of the stream
          exp_addr = exp_addr + 32'd4;
          accepted++;
        end
        hold_q     = valid_o && !ready_i;
        hold_entry = '{addr: addr_o, data: rdata_o};
      end
      branch_q = branch_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus driven on the falling edge
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic        held;
    rng_q = SEED;
    {rst_ni, req_i, branch_i, ready_i, held, hold_q, branch_q} = '0;
    addr_i       = '0;
    exp_addr     = '0;
    hold_entry   = '0;
    accepted     = 0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // quiet after reset
    repeat (3) begin
      @(posedge clk_i);
      assert (!valid_o && !instr_req_o && !busy_o) else report_error("activity after reset");
    end
    // the first target carries a byte offset
    @(negedge clk_i);
    {req_i, ready_i, branch_i} = 3'b111;
    addr_i = 32'h0000_1002;
    while (accepted < NUM_TXN) begin
      @(negedge clk_i);
      r        = draw();
      branch_i = 1'b0;
      ready_i  = (r[3:2] != 2'b00);
      if (!held && accepted >= NUM_TXN / 2) begin
        // long stall while the fifo fills and the head must hold
        held    = 1'b1;
        ready_i = 1'b0;
        repeat (40) @(negedge clk_i);
        ready_i = 1'b1;
      end else if (r[9:5] == 5'd0) begin
        // half the branches land while a granted response is in flight
        if (r[10]) begin
          ready_i = 1'b1;
          do @(posedge clk_i); while (!(instr_req_o && instr_gnt_i));
          @(negedge clk_i);
        end
        branch_i = 1'b1;
        addr_i   = draw();
      end
    end
    // stop fetching and drain
    @(negedge clk_i);
    {req_i, branch_i, ready_i} = 3'b001;
    do @(posedge clk_i); while (busy_o || valid_o);
    repeat (20) begin
      @(posedge clk_i);
      assert (!instr_req_o && !busy_o) else report_error("fetch activity with req_i low");
    end
    finish_run(1'b0);
  end

  // watchdog
  initial begin
    repeat (NUM_TXN * 40) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", NUM_TXN * 40);
    finish_run(1'b1);
  end

endmodule

// ==== tb_imem_model.sv ====
// instruction memory model
// grants after 0 to 3 request cycles, answers 1 to 3 cycles after the grant
// and checks that requests hold until granted and never overlap
module tb_imem_model #(
  parameter logic [31:0] SEED = 32'hcb236af2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                branch_i,
  input  logic                instr_req_i,
  input  prefetch_pkg::addr_t instr_addr_i,
  output logic                instr_gnt_o,
  output logic                instr_rvalid_o,
  output prefetch_pkg::addr_t instr_rdata_o,
  output int                  err_cnt_o
);
  import prefetch_pkg::*;

  logic [31:0] rng_q;
  // request seen on the bus without a grant
  logic        pend_q;
  addr_t       pend_addr_q;
  // granted and not answered yet
  logic        busy_q;
  addr_t       resp_addr_q;
  logic [1:0]  rv_wait_q;
  logic [1:0]  gnt_wait_q;
  // values put on the bus at the next falling edge
  logic        gnt_d;
  logic        rvalid_d;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // word stored at a byte address
  function automatic addr_t mem_word(input addr_t a);
    return ((a >> 2) * 32'h9e3779b1) ^ 32'h5a5a5a5a;
  endfunction

  initial begin
    rng_q          = SEED;
    err_cnt_o      = 0;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_q     = 1'b0;
      busy_q     = 1'b0;
      rv_wait_q  = 2'd0;
      gnt_wait_q = 2'd0;
      gnt_d      = 1'b0;
      rvalid_d   = 1'b0;
    end else begin
      // an ungranted request stays up with its address unless redirected
      if (pend_q) begin
        assert (instr_req_i && (branch_i || instr_addr_i == pend_addr_q)) else begin
          $display("protocol error at %0t: pending request dropped or moved", $time);
          err_cnt_o++;
        end
      end
      // only one request in flight
      if (busy_q && !instr_rvalid_o) begin
        assert (!instr_req_i) else begin
          $display("protocol error at %0t: request while a response is due", $time);
          err_cnt_o++;
        end
      end
      pend_q      = instr_req_i && !instr_gnt_o;
      pend_addr_q = instr_addr_i;
      if (instr_rvalid_o) begin
        busy_q = 1'b0;
      end
      if (instr_req_i && instr_gnt_o) begin
        rng_q       = lcg_next(rng_q);
        busy_q      = 1'b1;
        resp_addr_q = instr_addr_i;
        rv_wait_q   = (rng_q[17:16] == 2'd0) ? 2'd1 : rng_q[17:16];
        gnt_wait_q  = rng_q[25:24];
      end else if (instr_req_i && gnt_wait_q != 2'd0) begin
        gnt_wait_q = gnt_wait_q - 2'd1;
      end
      rvalid_d = 1'b0;
      if (busy_q && rv_wait_q != 2'd0) begin
        rv_wait_q = rv_wait_q - 2'd1;
        rvalid_d  = (rv_wait_q == 2'd0);
      end
      gnt_d = (gnt_wait_q == 2'd0);
    end
  end

  always @(negedge clk_i) begin
    instr_gnt_o    = gnt_d;
    instr_rvalid_o = rvalid_d;
    instr_rdata_o  = rvalid_d ? mem_word(resp_addr_q) : '0;
  end

endmodule

// ==== prefetch_buffer.sv ====
// instruction prefetch buffer
// fetches aligned words ahead of the core over a req/gnt/rvalid port
// and hands them out tagged with their addresses through valid/ready
module prefetch_buffer #(
  parameter int unsigned FIFO_DEPTH = 3
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // core side
  input  logic                req_i,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t addr_i,
  input  logic                ready_i,
  output logic                valid_o,
  output prefetch_pkg::addr_t rdata_o,
  output prefetch_pkg::addr_t addr_o,
  // instruction memory side
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  output prefetch_pkg::addr_t instr_addr_o,
  input  prefetch_pkg::addr_t instr_rdata_i,
  input  logic                instr_rvalid_i,
  // status
  output logic                busy_o
);
  import prefetch_pkg::*;

  logic         addr_load;
  logic         push;
  logic         pop;
  logic         room;
  addr_t        next_addr;
  addr_t        held_addr;
  addr_t        resp_addr;
  fetch_entry_t push_entry;
  fetch_entry_t head;

  // response data tagged with the address it answers
  assign push_entry = '{addr: resp_addr, data: instr_rdata_i};

  // the core takes the head entry
  assign pop = valid_o & ready_i;

  assign addr_o  = head.addr;
  assign rdata_o = head.data;

  fetch_fsm u_fetch_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (addr_i),
    .room_i        (room),
    .next_addr_i   (next_addr),
    .held_addr_i   (held_addr),
    .addr_load_o   (addr_load),
    .push_o        (push),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .busy_o        (busy_o)
  );

  fetch_addr_gen u_fetch_addr_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (addr_load),
    .load_addr_i(instr_addr_o),
    .push_i     (push),
    .next_addr_o(next_addr),
    .held_addr_o(held_addr),
    .resp_addr_o(resp_addr)
  );

  // a branch empties the buffer in the strobe cycle
  fetch_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fetch_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (branch_i),
    .push_i      (push),
    .push_entry_i(push_entry),
    .pop_i       (pop),
    .valid_o     (valid_o),
    .head_o      (head),
    .room_o      (room)
  );

endmodule

// ==== fetch_fsm.sv ====
// instruction fetch FSM
// drives the req/gnt phase of the instruction memory port, tracks the
// rvalid phase and drops a response that a branch has made stale
module fetch_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  // core side control
  input  logic                req_i,
  input  logic                branch_i,
  input  prefetch_pkg::addr_t branch_addr_i,
  // fifo can take the response of one more request
  input  logic                room_i,
  // address generator
  input  prefetch_pkg::addr_t next_addr_i,
  input  prefetch_pkg::addr_t held_addr_i,
  output logic                addr_load_o,
  // write the current response into the fifo
  output logic                push_o,
  // instruction memory port
  output logic                instr_req_o,
  output prefetch_pkg::addr_t instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  // fetch activity
  output logic                busy_o
);
  import prefetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  fetch_state_e issue_state;
  addr_t        branch_tgt;
  logic         fetch_ok;

  // branch targets are fetched from their word boundary
  assign branch_tgt = word_align(branch_addr_i);

  // a branch flushes the fifo and so always brings room with it
  assign fetch_ok = req_i & (room_i | branch_i);

  // where a request goes once it is on the bus
  assign issue_state = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;

  //////////////////////////////////////////////////////////////////////
  // next state and request decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_req_o  = 1'b0;
    instr_addr_o = branch_i ? branch_tgt : next_addr_i;
    addr_load_o  = 1'b0;
    push_o       = 1'b0;

    case (state_q)
      // with nothing outstanding start a fetch when asked and there is space
      IDLE: begin
        if (fetch_ok) begin
          instr_req_o = 1'b1;
          addr_load_o = 1'b1;
          state_d     = issue_state;
        end
      end

      // keep the request on the bus until it is granted
      WAIT_GNT: begin
        instr_req_o  = 1'b1;
        instr_addr_o = branch_i ? branch_tgt : held_addr_i;
        // a branch swaps the pending address before the grant
        addr_load_o  = branch_i;
        state_d      = issue_state;
      end

      // granted and waiting for the data
      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // response arriving with a branch belongs to the old stream
          push_o = ~branch_i;
          // back to back fetch in the same cycle as the data
          if (fetch_ok) begin
            instr_req_o = 1'b1;
            addr_load_o = 1'b1;
            state_d     = issue_state;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          // remember the target while the stale response is still due
          addr_load_o = 1'b1;
          state_d     = WAIT_ABORTED;
        end
      end

      // the target waits in the generator while the stale response is in flight
      WAIT_ABORTED: begin
        instr_addr_o = branch_i ? branch_tgt : held_addr_i;
        addr_load_o  = branch_i;
        if (instr_rvalid_i) begin
          // data is dropped here and the redirected request goes out
          if (req_i) begin
            instr_req_o = 1'b1;
            state_d     = issue_state;
          end else begin
            state_d = IDLE;
          end
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // busy while a request is pending, granted or being issued
  assign busy_o = (state_q != IDLE) | instr_req_o;

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // an ungranted request stays up with its address unless a branch redirects it
  addr_hold_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=>
      instr_req_o && (branch_i || instr_addr_o == $past(instr_addr_o))
  );

  // responses only arrive in the states that wait for one
  push_state_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> state_q == WAIT_RVALID || state_q == WAIT_ABORTED
  );

endmodule

// ==== fetch_fifo.sv ====
// fetch fifo
// circular buffer of address/data entries between the memory port and
// the core, flushed in one cycle on a branch; room_o keeps one slot
// free for the response of an outstanding request
module fetch_fifo #(
  parameter int unsigned FIFO_DEPTH = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // drop every stored entry
  input  logic                       flush_i,
  // write side
  input  logic                       push_i,
  input  prefetch_pkg::fetch_entry_t push_entry_i,
  // read side
  input  logic                       pop_i,
  output logic                       valid_o,
  output prefetch_pkg::fetch_entry_t head_o,
  // space left for one more request and its response
  output logic                       room_o
);
  import prefetch_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);
  localparam logic [CNT_W-1:0] CNT_ROOM = CNT_W'(FIFO_DEPTH - 2);

  fetch_entry_t     mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push_en;
  logic             pop_en;
  logic             full;

  // wrap at the last entry, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
  endfunction

  // flush overrides both sides
  assign push_en = push_i & ~flush_i;
  assign pop_en  = pop_i & ~flush_i;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // simultaneous push and pop leave the count alone
      case ({push_en, pop_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // registered head, no fall-through from the write side
  assign head_o  = mem_q[rd_ptr_q];
  assign valid_o = (cnt_q != '0);
  assign full    = (cnt_q == CNT_FULL);

  // one slot for a new request on top of the one possibly in flight
  assign room_o = (cnt_q <= CNT_ROOM);

  // the room reservation in front of the FSM keeps responses from overflowing
  no_push_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_i |-> flush_i || !full
  );

  // the core only takes entries that are presented
  no_pop_empty_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> valid_o
  );

endmodule

// ==== fetch_addr_gen.sv ====
// fetch address generator
// holds the last issued word address and the address of the response
// expected next, which tags every word written to the fifo
module fetch_addr_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  // a new request address was put on the bus
  input  logic                load_i,
  input  prefetch_pkg::addr_t load_addr_i,
  // the expected response was written to the fifo
  input  logic                push_i,
  output prefetch_pkg::addr_t next_addr_o,
  output prefetch_pkg::addr_t held_addr_o,
  output prefetch_pkg::addr_t resp_addr_o
);
  import prefetch_pkg::*;

  addr_t held_q;
  addr_t resp_q;

  // issued address that is re-driven while waiting for a grant or an abort
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= '0;
    end else if (load_i) begin
      held_q <= word_align(load_addr_i);
    end
  end

  // response address
  // a load in the push cycle wins while the push still sees the old tag
  // after a push into IDLE it runs one word ahead of held_q
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_q <= '0;
    end else if (load_i) begin
      resp_q <= word_align(load_addr_i);
    end else if (push_i) begin
      resp_q <= resp_q + WORD_INC;
    end
  end

  // sequential successor of the issued word
  assign next_addr_o = held_q + WORD_INC;
  assign held_addr_o = held_q;
  assign resp_addr_o = resp_q;

  // the bus only ever sees whole words
  load_aligned_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    load_i |-> load_addr_i[1:0] == 2'b00
  );

endmodule

// ==== prefetch_pkg.sv ====
// prefetch package
// shared types for the instruction prefetch unit: address width,
// the buffered fetch entry and the fetch FSM state encoding
package prefetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and basic types
  //////////////////////////////////////////////////////////////////////

  // address and instruction data share one 32-bit width
  localparam int unsigned ADDR_W = 32;

  // one address or one instruction word
  typedef logic [ADDR_W-1:0] addr_t;

  // byte step between consecutive aligned words
  localparam addr_t WORD_INC = addr_t'(4);

  //////////////////////////////////////////////////////////////////////
  // fetch entry and FSM state
  //////////////////////////////////////////////////////////////////////

  // one buffered word, tagged with the address it was fetched from
  typedef struct packed {
    addr_t addr;
    addr_t data;
  } fetch_entry_t;

  // request protocol states
  // WAIT_ABORTED waits out a response that a branch made stale
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

  // clear the byte offset, only whole words are fetched
  function automatic addr_t word_align(addr_t addr);
    return {addr[ADDR_W-1:2], 2'b00};
  endfunction

endpackage
